//--- runSim.sh
#!/usr/bin/env bash
# Builds the BCH decoder testbench with Verilator and runs it.

set -u
cd "$(dirname "$0")"

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bchDecoderTb \
	-f tb.f -Mdir "$OBJ" -o simBchDecoder > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/simBchDecoder" > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

if grep -q "Checks failed" "$SIM_LOG"; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
exit 0

//--- tb.f
verilog/bchFieldPkg.sv
verilog/bchCtrlPkg.sv
verilog/bchDecodeControl.sv
verilog/bchSyndrome.sv
verilog/bchBerlekamp.sv
verilog/bchChien.sv
verilog/bchDataBuffer.sv
verilog/bchDecoder.sv
tests/bchDecoderTb.sv

//--- tests/bchDecoderTb.sv
`timescale 1ns/1ps

module bchDecoderTb;

	localparam int N = 15;
	localparam int K = 5;
	localparam int T = 3;
	localparam int M = bchFieldPkg::fieldWidth(N);
	localparam int LAT = N + T + 1; // cycles from a bit going in to it coming out.
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_WORDS = 20;

	typedef struct packed {
		logic [K-1:0] msg;
		logic [N-1:0] err;
		logic [7:0] reps;
	} stimRow;

	logic clk;
	logic rstN;
	logic dataIn;
	logic dataOut;
	logic validOut;

	logic [N-1:0] genPoly;
	logic [1:0] expQ [$]; // one {message flag, expected bit} entry per driven cycle.
	stimRow rows [$];
	integer seed;
	int stepIdx;

	// the expected output of every row is its message.
	stimRow fixedRows [0:9] = '{
		'{5'b10110, 15'h0000, 8'd2}, // clean words.
		'{5'b00000, 15'h0000, 8'd1},
		'{5'b11111, 15'h0000, 8'd1},
		'{5'b01101, 15'h4000, 8'd1},
		'{5'b10011, 15'h2800, 8'd1},
		'{5'b11001, 15'h7000, 8'd1}, // three errors in the message.
		'{5'b00110, 15'h0C01, 8'd1},
		'{5'b10101, 15'h0007, 8'd1}, // parity errors only.
		'{5'b01010, 15'h0210, 8'd2},
		'{5'b11100, 15'h0400, 8'd1}
	};

	bchDecoder #(.N(N), .K(K), .T(T)) i_bchDecoder (
		.clk(clk), .rstN(rstN), .dataIn(dataIn), .dataOut(dataOut), .validOut(validOut)
	);

	always #5 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkBit(input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: dataOut is %b, expected %b", $time, got, exp));
	endtask

	task automatic checkValid(input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: validOut is %b, expected %b", $time, got, exp));
	endtask

	// g(x) is the product of the distinct minimal polynomials of alpha^1, alpha^3, ...
	task automatic buildGenerator();
		bchFieldPkg::gfElem mp [0:8];
		bchFieldPkg::gfElem root;
		logic [N-1:0] prod;
		bit used [0:255];
		int e;
		genPoly = N'(1);
		for (int i = 0; i < 256; i++)
			used[i] = 1'b0;
		for (int j = 1; j < 2 * T; j += 2) begin
			if (!used[j]) begin
				for (int i = 0; i <= 8; i++)
					mp[i] = (i == 0) ? 8'd1 : 8'd0;
				e = j;
				for (int c = 0; c < M && !used[e]; c++) begin
					used[e] = 1'b1; // walk the cyclotomic coset of j.
					root = bchFieldPkg::gfPowAlpha(e, M);
					for (int i = 8; i > 0; i--)
						mp[i] = mp[i - 1] ^ bchFieldPkg::gfMul(mp[i], root, M);
					mp[0] = bchFieldPkg::gfMul(mp[0], root, M);
					e = (2 * e) % ((1 << M) - 1);
				end
				prod = '0;
				for (int i = 0; i <= 8; i++) begin
					if (mp[i][0])
						prod ^= genPoly << i;
				end
				genPoly = prod;
			end
		end
	endtask

	function automatic logic [N-1:0] encodeWord(input logic [K-1:0] msg);
		logic [N-1:0] rem;
		rem = {msg, {(N-K){1'b0}}};
		for (int i = N - 1; i >= N - K; i--) begin
			if (rem[i])
				rem ^= genPoly << (i - (N - K));
		end
		return {msg, rem[N-K-1:0]};
	endfunction

	task automatic addRandomRows();
		stimRow r;
		int count;
		int pos;
		for (int w = 0; w < RANDOM_WORDS; w++) begin
			r.msg = K'($random(seed));
			r.err = '0;
			r.reps = 8'd1;
			count = $unsigned($random(seed)) % (T + 1);
			for (int tries = 0; tries < 8 * N && $countones(r.err) < count; tries++) begin
				pos = $unsigned($random(seed)) % N;
				r.err[pos] = 1'b1;
			end
			rows.push_back(r);
		end
	endtask

	// Check the bit that went in LAT cycles ago, drive the next one, move to the next negedge.
	task automatic stepCycle(input logic bitIn, input logic [1:0] entry, input logic track);
		logic [1:0] exp;
		if (stepIdx >= LAT) begin
			if (expQ.size() == 0) begin
				failRun("the output check ran out of expected entries");
			end else begin
				exp = expQ.pop_front();
				checkValid(validOut, exp[1]);
				if (exp[1])
					checkBit(dataOut, exp[0]);
			end
		end else begin
			checkValid(validOut, 1'b0);
		end
		dataIn = bitIn;
		if (track)
			expQ.push_back(entry);
		stepIdx++;
		@(negedge clk);
	endtask

	task automatic streamWord(input logic [K-1:0] msg, input logic [N-1:0] err);
		logic [N-1:0] rx;
		rx = encodeWord(msg) ^ err;
		for (int j = 0; j < N; j++) begin
			if (j < K)
				stepCycle(rx[N-1-j], {1'b1, msg[K-1-j]}, 1'b1);
			else
				stepCycle(rx[N-1-j], 2'b00, 1'b1);
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		dataIn = 1'b0;
		seed = 52092;
		stepIdx = 0;
		buildGenerator();
		if ((genPoly >> (N - K)) != 1)
			failRun("generator polynomial degree does not equal N-K");
		for (int i = 0; i < 10; i++)
			rows.push_back(fixedRows[i]);
		addRandomRows();

		// bits that arrive during reset belong to no word.
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(negedge clk);
			checkValid(validOut, 1'b0);
			if (c < RESET_CYCLES - 1)
				dataIn = 1'($random(seed));
		end
		rstN = 1'b1;

		for (int i = 0; i < rows.size(); i++) begin
			for (int r = 0; r < rows[i].reps; r++)
				streamWord(rows[i].msg, rows[i].err);
		end

		for (int c = 0; expQ.size() > 0; c++) begin
			if (c > LAT + N)
				failRun("timeout while waiting for the last word to leave the decoder");
			else
				stepCycle(1'b0, 2'b00, 1'b0);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/bchBerlekamp.sv
`timescale 1ns/1ps

module bchBerlekamp #(
	parameter int N = 15,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	input  logic solveStart,
	input  bchFieldPkg::gfElem syndrome [0:2*bchFieldPkg::maxT-1],
	input  bchCtrlPkg::bchPhase phase,
	output bchFieldPkg::gfElem locator [0:bchFieldPkg::maxT],
	output logic locDone
);

	localparam int M = bchFieldPkg::fieldWidth(N);
	localparam int D = bchFieldPkg::maxT;

	bchFieldPkg::gfElem synReg [0:2*D-1];
	bchFieldPkg::gfElem synSrc [0:2*D-1];
	bchFieldPkg::gfElem sigReg [0:D];
	bchFieldPkg::gfElem lamReg [0:D];
	bchFieldPkg::gfElem sigCur [0:D];
	bchFieldPkg::gfElem lamCur [0:D];
	bchFieldPkg::gfElem sigNext [0:D];
	bchFieldPkg::gfElem lamNext [0:D];
	bchFieldPkg::gfElem deltaReg, deltaCur, deltaNext, disc;
	logic [3:0] lReg, lCur, lNext;
	logic [3:0] iterK, kNow;
	logic busy;
	logic grow;

	// iteration zero runs straight off the syndrome inputs.
	always_comb begin
		int idx;
		kNow = solveStart ? 4'd0 : iterK;
		deltaCur = solveStart ? 8'd1 : deltaReg;
		lCur = solveStart ? 4'd0 : lReg;
		for (int j = 0; j < 2 * D; j++)
			synSrc[j] = solveStart ? syndrome[j] : synReg[j];
		for (int i = 0; i <= D; i++) begin
			sigCur[i] = solveStart ? ((i == 0) ? 8'd1 : 8'd0) : sigReg[i];
			lamCur[i] = solveStart ? ((i == 0) ? 8'd1 : 8'd0) : lamReg[i];
		end
		disc = '0;
		for (int i = 0; i <= T; i++) begin
			idx = 2 * kNow - i;
			if (idx >= 0)
				disc ^= bchFieldPkg::gfMul(sigCur[i], synSrc[idx], M);
		end
		grow = (disc != 0) && (lCur <= kNow); // degree must rise.
		for (int i = 0; i <= D; i++) begin
			sigNext[i] = bchFieldPkg::gfMul(deltaCur, sigCur[i], M);
			if (i > 0)
				sigNext[i] ^= bchFieldPkg::gfMul(disc, lamCur[i - 1], M);
			if (grow)
				lamNext[i] = (i > 0) ? sigCur[i - 1] : 8'd0;
			else
				lamNext[i] = (i > 1) ? lamCur[i - 2] : 8'd0;
			if (i > T) begin
				sigNext[i] = '0;
				lamNext[i] = '0;
			end
		end
		deltaNext = grow ? disc : deltaCur;
		lNext = grow ? 4'(2 * kNow + 1 - lCur) : lCur;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			iterK <= '0;
			locDone <= 1'b0;
		end else begin
			locDone <= (solveStart || busy) && kNow == 4'(T - 1);
			if (solveStart) begin
				busy <= (T > 1);
				iterK <= 4'd1;
			end else if (busy) begin
				iterK <= iterK + 4'd1;
				if (iterK == 4'(T - 1))
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (solveStart)
			synReg <= syndrome;
		if (solveStart || busy) begin
			sigReg <= sigNext;
			lamReg <= lamNext;
			deltaReg <= deltaNext;
			lReg <= lNext;
		end
	end

	assign locator = sigReg;

	aSolvePhase: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> phase == bchCtrlPkg::phaseSolve);

endmodule

//--- verilog/bchChien.sv
`timescale 1ns/1ps

module bchChien #(
	parameter int N = 15,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	input  logic searchLoad,
	input  bchFieldPkg::gfElem locator [0:bchFieldPkg::maxT],
	output logic errFlag
);

	localparam int M = bchFieldPkg::fieldWidth(N);

	bchFieldPkg::gfElem term [0:bchFieldPkg::maxT];
	bchFieldPkg::gfElem prod [0:bchFieldPkg::maxT];
	bchFieldPkg::gfElem sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i <= bchFieldPkg::maxT; i++) begin
			if (i > T)
				prod[i] = '0;
			else
				prod[i] = bchFieldPkg::gfMul(searchLoad ? locator[i] : term[i],
					bchFieldPkg::gfPowAlpha(i, M), M);
			sum ^= prod[i];
		end
	end

	// step s tests position N-1-s, a root at alpha^(s+1).
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			errFlag <= 1'b0;
			for (int i = 0; i <= bchFieldPkg::maxT; i++)
				term[i] <= '0;
		end else begin
			term <= prod;
			errFlag <= (sum == 0) && (prod[0] != 0); // idle terms are all zero.
		end
	end

endmodule

//--- verilog/bchCtrlPkg.sv
package bchCtrlPkg;

	// stage that control is driving for the word it tracks.
	typedef enum logic [1:0] {
		phaseCollect,
		phaseSolve,
		phaseSearch
	} bchPhase;

endpackage

//--- verilog/bchDataBuffer.sv
`timescale 1ns/1ps

module bchDataBuffer #(
	parameter int N = 15,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	input  logic dataIn,
	input  logic errFlag,
	output logic dataOut
);

	localparam int DEPTH = N + T + 1;

	logic [DEPTH-1:0] shift;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			shift <= '0;
		else
			shift <= {shift[DEPTH-2:0], dataIn};
	end

	// The flag for a bit lands on the same cycle as the bit leaves the line.
	assign dataOut = shift[DEPTH-1] ^ errFlag;

endmodule

//--- verilog/bchDecodeControl.sv
`timescale 1ns/1ps

module bchDecodeControl #(
	parameter int N = 15,
	parameter int K = 5,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	output logic synClear,
	output logic solveStart,
	output logic searchLoad,
	output logic validOut,
	output bchCtrlPkg::bchPhase phase
);

	logic [$clog2(N)-1:0] bitIdx;
	logic [$clog2(T+1):0] dly;
	logic [$clog2(K+1):0] validCnt;
	logic wordSeen;
	logic pend;
	logic wordStart;

	// no word boundary is reported until one whole word has arrived.
	assign wordStart = (bitIdx == 0) && wordSeen;
	assign synClear = wordStart;
	assign solveStart = wordStart;
	assign searchLoad = pend && dly == T;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bitIdx <= '0;
			wordSeen <= 1'b0;
		end else begin
			bitIdx <= (bitIdx == N - 1) ? '0 : bitIdx + 1'b1;
			if (bitIdx == N - 1)
				wordSeen <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pend <= 1'b0;
			dly <= '0;
		end else if (solveStart) begin
			pend <= 1'b1;
			dly <= 1;
		end else if (searchLoad) begin
			pend <= 1'b0;
		end else if (pend) begin
			dly <= dly + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validOut <= 1'b0;
			validCnt <= '0;
		end else if (searchLoad) begin
			validOut <= 1'b1; // first message bit leaves next cycle.
			validCnt <= 1;
		end else if (validOut) begin
			if (validCnt == K)
				validOut <= 1'b0;
			else
				validCnt <= validCnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			phase <= bchCtrlPkg::phaseCollect;
		else if (solveStart)
			phase <= bchCtrlPkg::phaseSolve;
		else if (searchLoad)
			phase <= bchCtrlPkg::phaseSearch;
	end

	aStrobeApart: assert property (@(posedge clk) disable iff (!rstN)
		!(solveStart && searchLoad));

	aValidLength: assert property (@(posedge clk) disable iff (!rstN)
		$rose(validOut) |-> validOut [*K] ##1 !validOut);

endmodule

//--- verilog/bchDecoder.sv
`timescale 1ns/1ps

module bchDecoder #(
	parameter int N = 15,
	parameter int K = 5,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	input  logic dataIn,
	output logic dataOut,
	output logic validOut
);

	logic synClear;
	logic solveStart;
	logic searchLoad;
	logic locDone;
	logic errFlag;
	bchCtrlPkg::bchPhase phase;
	bchFieldPkg::gfElem syndrome [0:2*bchFieldPkg::maxT-1];
	bchFieldPkg::gfElem locator [0:bchFieldPkg::maxT];

	bchDecodeControl #(.N(N), .K(K), .T(T)) i_bchDecodeControl (
		.clk(clk), .rstN(rstN), .synClear(synClear), .solveStart(solveStart),
		.searchLoad(searchLoad), .validOut(validOut), .phase(phase)
	);

	bchSyndrome #(.N(N), .T(T)) i_bchSyndrome (
		.clk(clk), .rstN(rstN), .dataIn(dataIn), .synClear(synClear),
		.syndrome(syndrome)
	);

	bchBerlekamp #(.N(N), .T(T)) i_bchBerlekamp (
		.clk(clk), .rstN(rstN), .solveStart(solveStart), .syndrome(syndrome),
		.phase(phase), .locator(locator), .locDone(locDone)
	);

	bchChien #(.N(N), .T(T)) i_bchChien (
		.clk(clk), .rstN(rstN), .searchLoad(searchLoad), .locator(locator),
		.errFlag(errFlag)
	);

	bchDataBuffer #(.N(N), .T(T)) i_bchDataBuffer (
		.clk(clk), .rstN(rstN), .dataIn(dataIn), .errFlag(errFlag),
		.dataOut(dataOut)
	);

	// the locator is final on the cycle that the search copies it.
	aLocReady: assert property (@(posedge clk) disable iff (!rstN)
		locDone |-> searchLoad);

endmodule

//--- verilog/bchFieldPkg.sv
package bchFieldPkg;

	localparam int maxT = 4; // largest correctable error count supported.

	typedef logic [7:0] gfElem;

	function automatic int fieldWidth(input int n);
		for (int m = 3; m <= 8; m++) begin
			if ((1 << m) - 1 >= n)
				return m;
		end
		return 8;
	endfunction

	function automatic logic [8:0] primPoly(input int m);
		case (m)
			3: return 9'b000001011;
			4: return 9'b000010011;
			5: return 9'b000100101;
			6: return 9'b001000011;
			7: return 9'b010001001;
			default: return 9'b100011101;
		endcase
	endfunction

	function automatic gfElem gfMul(input gfElem a, input gfElem b, input int m);
		logic [8:0] acc;
		logic [8:0] sh;
		acc = '0;
		sh = {1'b0, a};
		for (int i = 0; i < 8; i++) begin
			if (i < m && b[i])
				acc ^= sh;
			sh = sh << 1;
			if (sh[m])
				sh ^= primPoly(m); // reduce back into the field.
		end
		return acc[7:0];
	endfunction

	function automatic gfElem gfPowAlpha(input int e, input int m);
		gfElem r;
		r = 8'd1;
		for (int i = 0; i < e % ((1 << m) - 1); i++)
			r = gfMul(r, 8'd2, m);
		return r;
	endfunction

endpackage

//--- verilog/bchSyndrome.sv
`timescale 1ns/1ps

module bchSyndrome #(
	parameter int N = 15,
	parameter int T = 3
) (
	input  logic clk,
	input  logic rstN,
	input  logic dataIn,
	input  logic synClear,
	output bchFieldPkg::gfElem syndrome [0:2*bchFieldPkg::maxT-1]
);

	localparam int M = bchFieldPkg::fieldWidth(N);

	bchFieldPkg::gfElem acc [0:bchFieldPkg::maxT-1]; // acc[m] holds S(2m+1).

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int m = 0; m < bchFieldPkg::maxT; m++)
				acc[m] <= '0;
		end else begin
			for (int m = 0; m < bchFieldPkg::maxT; m++) begin
				if (m >= T)
					acc[m] <= '0;
				else if (synClear)
					acc[m] <= {7'd0, dataIn}; // first bit of a new word.
				else
					acc[m] <= bchFieldPkg::gfMul(acc[m],
						bchFieldPkg::gfPowAlpha(2 * m + 1, M), M) ^ {7'd0, dataIn};
			end
		end
	end

	// Even syndromes are squares of lower ones in a binary code.
	always_comb begin
		for (int j = 0; j < 2 * bchFieldPkg::maxT; j++) begin
			if (j >= 2 * T)
				syndrome[j] = '0;
			else if (j % 2 == 0)
				syndrome[j] = acc[j / 2];
			else
				syndrome[j] = bchFieldPkg::gfMul(syndrome[(j - 1) / 2],
					syndrome[(j - 1) / 2], M);
		end
	end

endmodule
